// File: compile.f
+incdir+design
design/uart_pkg.sv
design/dbg_pkg.sv
design/uart_baud_timer.sv
design/uart_rx_frame.sv
design/uart_tx_frame.sv
design/dbg_mem.sv
design/dbg_cmd_fsm.sv
design/uart_dbg_server.sv
tb/uart_dbg_properties.sv
tb/tb_uart_dbg_server.sv

// File: design/dbg_cmd_fsm.sv
// Debug protocol FSM: command decode, header capture, memory and reply control
`timescale 1ns/1ps

module dbg_cmd_fsm (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  uart_pkg::uart_rx_t    rx_byte_i,
  input  logic                  tx_busy_i,
  output logic                  tx_send_o,
  output uart_pkg::uart_byte_t  tx_data_o,
  output dbg_pkg::dbg_mem_req_s mem_req_o,
  input  uart_pkg::uart_byte_t  mem_rdata_i,
  output dbg_pkg::dbg_exec_s    exec_o
);

  import uart_pkg::*;
  import dbg_pkg::*;

  localparam int unsigned HCNT_W = $clog2(DBG_HDR_BYTES);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR,
    S_ACK,
    S_DATA,
    S_EOT,
    S_EXEC
  } state_e;

  state_e            state_q;
  dbg_cmd_e          cmd_q;
  logic [HCNT_W-1:0] hdr_cnt_q;
  logic [HCNT_W-1:0] hdr_last;
  logic              rd_wait_q;
  dbg_hdr_u          hdr_q;
  dbg_addr_t         addr_q;
  dbg_addr_t         remain_q;
  logic              rx_ok;
  logic              beat_done;

  // Input is ignored while a reply goes out
  assign rx_ok = rx_byte_i.valid & ~tx_busy_i;

  // EXEC carries the address only
  assign hdr_last = (cmd_q == CMD_EXEC) ? HCNT_W'(DBG_HDR_BYTES / 2 - 1)
                                        : HCNT_W'(DBG_HDR_BYTES - 1);

  ////////////////////////////////////////////////////////////////////
  // Transmit and memory requests
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_send_o       = 1'b0;
    tx_data_o       = CMD_ACK;
    mem_req_o       = '0;
    mem_req_o.idx   = addr_q[DBG_IDX_W-1:0];
    mem_req_o.wdata = rx_byte_i.data;
    case (state_q)
      S_ACK: tx_send_o = ~tx_busy_i;
      S_EOT: begin
        tx_send_o = ~tx_busy_i;
        tx_data_o = CMD_EOT;
      end
      S_DATA: begin
        if (cmd_q == CMD_WRITE) begin
          mem_req_o.we = rx_ok;
        end else begin
          // Request first, send on the cycle the data returns
          mem_req_o.re = ~rd_wait_q & ~tx_busy_i;
          tx_send_o    = rd_wait_q;
          tx_data_o    = mem_rdata_i;
        end
      end
      default: ;
    endcase
  end

  // One byte moved in either direction
  assign beat_done = mem_req_o.we | (state_q == S_DATA && tx_send_o);

  ////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      cmd_q     <= CMD_ACK;
      hdr_cnt_q <= '0;
      rd_wait_q <= 1'b0;
      exec_o    <= '0;
    end else begin
      exec_o.strobe <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (rx_ok) begin
            case (rx_byte_i.data)
              CMD_ACK: begin
                cmd_q   <= CMD_ACK;
                state_q <= S_ACK;
              end
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q     <= dbg_cmd_e'(rx_byte_i.data);
                hdr_cnt_q <= '0;
                state_q   <= S_HDR;
              end
              // Anything else gets no reply
              default: ;
            endcase
          end
        end
        S_HDR: begin
          if (rx_ok) begin
            hdr_cnt_q <= hdr_cnt_q + HCNT_W'(1);
            if (hdr_cnt_q == hdr_last) begin
              state_q <= S_ACK;
            end
          end
        end
        S_ACK: begin
          if (tx_send_o) begin
            case (cmd_q)
              CMD_ACK:  state_q <= S_IDLE;
              CMD_EXEC: state_q <= S_EXEC;
              default:  state_q <= (hdr_q.f.len == '0) ? S_EOT : S_DATA;
            endcase
          end
        end
        S_DATA: begin
          if (mem_req_o.re) begin
            rd_wait_q <= 1'b1;
          end
          if (beat_done) begin
            rd_wait_q <= 1'b0;
            if (remain_q == dbg_addr_t'(1)) begin
              state_q <= S_EOT;
            end
          end
        end
        S_EOT: begin
          if (tx_send_o) begin
            state_q <= S_IDLE;
          end
        end
        S_EXEC: begin
          // Fire once the ACK stop bit is out
          if (!tx_busy_i) begin
            exec_o  <= '{strobe: 1'b1, addr: addr_q};
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Header bytes and transfer pointers
  always_ff @(posedge clk) begin
    if (state_q == S_HDR && rx_ok) begin
      hdr_q.bytes[hdr_cnt_q] <= rx_byte_i.data;
    end
    if (state_q == S_ACK && tx_send_o) begin
      addr_q   <= hdr_q.f.addr;
      remain_q <= hdr_q.f.len;
    end else if (beat_done) begin
      addr_q   <= addr_q + dbg_addr_t'(1);
      remain_q <= remain_q - dbg_addr_t'(1);
    end
  end

endmodule

// File: design/dbg_mem.sv
// Byte-wide debug memory, synchronous write and registered read
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_mem (
  input  logic                  clk,
  input  dbg_pkg::dbg_mem_req_s req_i,
  output uart_pkg::uart_byte_t  rdata_o
);

  logic [7:0] mem_q [`DBG_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (req_i.we) begin
      mem_q[req_i.idx] <= req_i.wdata;
    end
    // Data is valid the cycle after the request
    if (req_i.re) begin
      rdata_o <= mem_q[req_i.idx];
    end
  end

endmodule

// File: design/dbg_pkg.sv
// Debug protocol types: command codes, header word, memory and exec requests
`include "dbg_settings.svh"

package dbg_pkg;

  // Byte index into the debug memory
  localparam int unsigned DBG_IDX_W = $clog2(`DBG_MEM_DEPTH);

  // Address plus length, in bytes
  localparam int unsigned DBG_HDR_BYTES = 2 * `DBG_ADDR_W / 8;

  // Command and reply codes on the wire
  typedef enum logic [7:0] {
    CMD_EOT   = 8'h04,
    CMD_ACK   = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_cmd_e;

  typedef logic [`DBG_ADDR_W-1:0] dbg_addr_t;

  // Address sits in the low half, so it arrives first
  typedef struct packed {
    dbg_addr_t len;
    dbg_addr_t addr;
  } dbg_hdr_s;

  // Filled byte by byte, read back as fields
  typedef union packed {
    dbg_hdr_s                                f;
    uart_pkg::uart_byte_t [DBG_HDR_BYTES-1:0] bytes;
  } dbg_hdr_u;

  typedef struct packed {
    logic                 we;
    logic                 re;
    logic [DBG_IDX_W-1:0] idx;
    uart_pkg::uart_byte_t wdata;
  } dbg_mem_req_s;

  // Execution request towards the core
  typedef struct packed {
    logic      strobe;
    dbg_addr_t addr;
  } dbg_exec_s;

endpackage

// File: design/dbg_settings.svh
// UART debug server build settings: bit timing, memory size and field widths
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Serial line timing
//////////////////////////////////////////////////////////////////////

// Clock cycles per serial bit, even values only
`define DBG_CLKS_PER_BIT 16

//////////////////////////////////////////////////////////////////////
// Debug protocol
//////////////////////////////////////////////////////////////////////

// Byte memory size, power of two so addresses wrap cleanly
`define DBG_MEM_DEPTH 256

// Address and length fields, sent little-endian
`define DBG_ADDR_W 16

`endif

// File: design/uart_baud_timer.sv
// Bit period counter giving mid-bit sample and bit-end ticks
`timescale 1ns/1ps
`include "dbg_settings.svh"

module uart_baud_timer (
  input  logic clk,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic run_i,
  output logic mid_o,
  output logic end_o
);

  localparam int unsigned CNT_W = $clog2(`DBG_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DBG_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`DBG_CLKS_PER_BIT / 2 - 1);

  logic [CNT_W-1:0] cnt_q;

  // Counter restarts on start and stays cleared while idle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (start_i || !run_i) begin
      cnt_q <= '0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  // No ticks on the restart cycle, the count may be stale there
  assign mid_o = run_i & ~start_i & (cnt_q == CNT_HALF);
  assign end_o = run_i & ~start_i & (cnt_q == CNT_LAST);

endmodule

// File: design/uart_dbg_server.sv
// UART debug server top: framers, bit timers, protocol FSM and byte memory
`timescale 1ns/1ps

module uart_dbg_server (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               rx_i,
  output logic               tx_o,
  output dbg_pkg::dbg_exec_s exec_o
);

  import uart_pkg::*;
  import dbg_pkg::*;

  logic         rx_start;
  logic         rx_run;
  logic         rx_mid;
  uart_rx_t     rx_byte;
  logic         tx_start;
  logic         tx_run;
  logic         tx_end;
  logic         tx_send;
  logic         tx_busy;
  uart_byte_t   tx_data;
  dbg_mem_req_s mem_req;
  uart_byte_t   mem_rdata;

  //////////////////////////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////////////////////////

  uart_baud_timer u_rx_timer (
    .clk     ( clk      ),
    .rst_n_i ( rst_n_i  ),
    .start_i ( rx_start ),
    .run_i   ( rx_run   ),
    .mid_o   ( rx_mid   ),
    .end_o   (          )
  );

  uart_rx_frame u_rx_frame (
    .clk     ( clk      ),
    .rst_n_i ( rst_n_i  ),
    .rx_i    ( rx_i     ),
    .mid_i   ( rx_mid   ),
    .start_o ( rx_start ),
    .run_o   ( rx_run   ),
    .byte_o  ( rx_byte  )
  );

  //////////////////////////////////////////////////////////////////////
  // Transmit side
  //////////////////////////////////////////////////////////////////////

  uart_baud_timer u_tx_timer (
    .clk     ( clk      ),
    .rst_n_i ( rst_n_i  ),
    .start_i ( tx_start ),
    .run_i   ( tx_run   ),
    .mid_o   (          ),
    .end_o   ( tx_end   )
  );

  uart_tx_frame u_tx_frame (
    .clk     ( clk      ),
    .rst_n_i ( rst_n_i  ),
    .send_i  ( tx_send  ),
    .data_i  ( tx_data  ),
    .end_i   ( tx_end   ),
    .start_o ( tx_start ),
    .run_o   ( tx_run   ),
    .busy_o  ( tx_busy  ),
    .tx_o    ( tx_o     )
  );

  //////////////////////////////////////////////////////////////////////
  // Protocol and storage
  //////////////////////////////////////////////////////////////////////

  dbg_cmd_fsm u_cmd_fsm (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .rx_byte_i   ( rx_byte   ),
    .tx_busy_i   ( tx_busy   ),
    .tx_send_o   ( tx_send   ),
    .tx_data_o   ( tx_data   ),
    .mem_req_o   ( mem_req   ),
    .mem_rdata_i ( mem_rdata ),
    .exec_o      ( exec_o    )
  );

  dbg_mem u_mem (
    .clk     ( clk       ),
    .req_i   ( mem_req   ),
    .rdata_o ( mem_rdata )
  );

endmodule

// File: design/uart_pkg.sv
// Serial line layer types shared by the UART framers and the protocol FSM
package uart_pkg;

  // One payload byte of an 8N1 frame
  typedef logic [7:0] uart_byte_t;

  // Received byte with its one-cycle strobe
  typedef struct packed {
    logic       valid;
    uart_byte_t data;
  } uart_rx_t;

endpackage

// File: design/uart_rx_frame.sv
// 8N1 receiver: start detection, LSB-first shift and stop bit check
`timescale 1ns/1ps

module uart_rx_frame (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                rx_i,
  input  logic                mid_i,
  output logic                start_o,
  output logic                run_o,
  output uart_pkg::uart_rx_t  byte_o
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    R_IDLE,
    R_START,
    R_DATA,
    R_STOP
  } rx_state_e;

  rx_state_e  state_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  logic       rx_prev_q;
  logic [2:0] bit_cnt_q;
  logic       valid_q;
  uart_byte_t shift_q;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  // Falling edge on an idle line starts the bit timer
  assign start_o = (state_q == R_IDLE) & rx_prev_q & ~rx_sync_q;
  assign run_o   = (state_q != R_IDLE);

  ////////////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= R_IDLE;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        R_IDLE: begin
          if (start_o) begin
            state_q <= R_START;
          end
        end
        R_START: begin
          // A glitch that is gone by mid-bit is not a start bit
          if (mid_i) begin
            state_q   <= rx_sync_q ? R_IDLE : R_DATA;
            bit_cnt_q <= '0;
          end
        end
        R_DATA: begin
          if (mid_i) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= R_STOP;
            end
          end
        end
        R_STOP: begin
          if (mid_i) begin
            // Framing error drops the byte silently
            valid_q <= rx_sync_q;
            state_q <= R_IDLE;
          end
        end
        default: state_q <= R_IDLE;
      endcase
    end
  end

  // Data path shifts in LSB first
  always_ff @(posedge clk) begin
    if (state_q == R_DATA && mid_i) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign byte_o = '{valid: valid_q, data: shift_q};

endmodule

// File: design/uart_tx_frame.sv
// 8N1 transmitter shifting a ten-bit frame out on bit-end ticks
`timescale 1ns/1ps

module uart_tx_frame (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 send_i,
  input  uart_pkg::uart_byte_t data_i,
  input  logic                 end_i,
  output logic                 start_o,
  output logic                 run_o,
  output logic                 busy_o,
  output logic                 tx_o
);

  logic [9:0] frame_q;
  logic [3:0] bit_cnt_q;
  logic       busy_q;

  // Send strobes are ignored while a frame is in flight
  assign start_o = send_i & ~busy_q;

  ////////////////////////////////////////////////////////////////////
  // Frame shifter
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      frame_q   <= '1;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (start_o) begin
      // Stop, data, start; bit 0 goes out first
      frame_q   <= {1'b1, data_i, 1'b0};
      bit_cnt_q <= '0;
      busy_q    <= 1'b1;
    end else if (busy_q && end_i) begin
      // Shift in ones so the line rests high afterwards
      frame_q   <= {1'b1, frame_q[9:1]};
      bit_cnt_q <= bit_cnt_q + 4'd1;
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign run_o  = busy_q;
  assign busy_o = busy_q;
  assign tx_o   = frame_q[0];

endmodule

// File: tb/dbg_patterns.txt
// Each word is a kind nibble followed by a 16-bit value
// Kind 0 sends a byte, 1 expects a reply byte, 2 expects an exec pulse at the address
// ACK challenge
00006 10006
// WRITE four bytes at 0x0010
00012 00010 00000 00004 00000 10006
000DE 000AD 000BE 000EF 10004
// READ the same four bytes
00011 00010 00000 00004 00000 10006
100DE 100AD 100BE 100EF 10004
// WRITE one byte at 0x01FF, READ it back at 0x00FF
00012 000FF 00001 00001 00000 10006 000A5 10004
00011 000FF 00000 00001 00000 10006 100A5 10004
// READ with length zero
00011 00000 00000 00000 00000 10006 10004
// Unknown byte gets no reply, ACK challenge still answered
00055 00006 10006
// EXEC at 0x1234
00013 00034 00012 10006 21234

// File: tb/tb_uart_dbg_server.sv
// Testbench for the UART debug server, driven from a pattern file of bytes and replies
`timescale 1ns/1ps
`include "dbg_settings.svh"

module tb_uart_dbg_server;

  import uart_pkg::*;
  import dbg_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned PAT_MAX    = 64;
  localparam int unsigned BIT_CLKS   = `DBG_CLKS_PER_BIT;

  logic        clk;
  logic        rst_n_i;
  logic        rx_i;
  logic        tx_o;
  dbg_exec_s   exec_o;

  // Kind nibble in bits 19:16 above the value
  logic [19:0] pat_mem [PAT_MAX];
  int unsigned pat_count;
  uart_byte_t  reply_q [$];
  dbg_addr_t   exec_q [$];

  uart_dbg_server u_uart_dbg_server (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .rx_i    ( rx_i    ),
    .tx_o    ( tx_o    ),
    .exec_o  ( exec_o  )
  );

  bind uart_dbg_server uart_dbg_properties u_props (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .tx_o    ( tx_o    ),
    .exec_o  ( exec_o  )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic end_in_failure();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    end_in_failure();
  endtask

  task automatic check_byte(input uart_byte_t exp, input uart_byte_t got);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: reply byte %02h, expected %02h", $time, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_exec(input dbg_addr_t exp, input dbg_addr_t got);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: exec address %04h, expected %04h", $time, got, exp);
      end_in_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Serial line host side
  //////////////////////////////////////////////////////////////////////

  // Start bit, data LSB first, stop bit
  task automatic send_byte(input uart_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(negedge clk);
    for (int i = 0; i < 10; i++) begin
      rx_i = frame[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
  endtask

  // Sample near the middle of each bit
  task automatic receive_byte(output uart_byte_t b);
    @(negedge tx_o);
    repeat (BIT_CLKS / 2) @(negedge clk);
    if (tx_o !== 1'b0) begin
      report_failure("start bit on the tx line did not last half a bit");
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = tx_o;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (tx_o !== 1'b1) begin
      report_failure("stop bit on the tx line is low");
    end
  endtask

  task automatic watch_time(input int unsigned pats);
    #(longint'(pats) * 20 * BIT_CLKS * CLK_PERIOD);
    report_failure("no reply from server within time limit");
  endtask

  // Reply collector
  initial begin
    uart_byte_t b;
    wait (rst_n_i === 1'b1);
    forever begin
      receive_byte(b);
      reply_q.push_back(b);
    end
  end

  // Exec collector samples away from the active edge
  initial begin
    wait (rst_n_i === 1'b1);
    forever begin
      @(negedge clk);
      if (exec_o.strobe === 1'b1) begin
        exec_q.push_back(exec_o.addr);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pattern sequencer
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [3:0] kind;
    logic [15:0] value;
    rx_i    = 1'b1;
    rst_n_i = 1'b0;
    // Kind F marks the end of the loaded patterns
    for (int i = 0; i < PAT_MAX; i++) begin
      pat_mem[i] = {4'hF, 16'(i)};
    end
    $readmemh("tb/dbg_patterns.txt", pat_mem);
    pat_count = 0;
    while (pat_count < PAT_MAX && pat_mem[pat_count][19:16] !== 4'hF) begin
      pat_count++;
    end
    if (pat_count == 0) begin
      report_failure("pattern file is missing or holds no patterns");
    end
    fork
      watch_time(pat_count);
    join_none
    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (4) @(negedge clk);
    for (int i = 0; i < pat_count; i++) begin
      kind  = pat_mem[i][19:16];
      value = pat_mem[i][15:0];
      case (kind)
        4'h0: send_byte(value[7:0]);
        4'h1: begin
          while (reply_q.size() == 0) @(negedge clk);
          check_byte(value[7:0], reply_q.pop_front());
        end
        4'h2: begin
          while (exec_q.size() == 0) @(negedge clk);
          check_exec(value, exec_q.pop_front());
        end
        default: report_failure("pattern file holds an unknown pattern kind");
      endcase
    end
    // Leave room for a stray reply to show up
    repeat (12 * BIT_CLKS) @(negedge clk);
    if (reply_q.size() != 0 || exec_q.size() != 0) begin
      report_failure("server sent a reply or exec pulse that no pattern expected");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: tb/uart_dbg_properties.sv
// UART debug server port checks: idle line in reset and single-cycle exec strobe
`timescale 1ns/1ps

module uart_dbg_properties (
  input logic               clk,
  input logic               rst_n_i,
  input logic               tx_o,
  input dbg_pkg::dbg_exec_s exec_o
);

  // Set once reset has been sampled by a clock edge
  logic reset_seen_q;

  always_ff @(posedge clk) begin
    reset_seen_q <= !rst_n_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reset behavior
  //////////////////////////////////////////////////////////////////////

  property tx_idle_in_reset_p;
    @(posedge clk) (!rst_n_i && reset_seen_q) |-> tx_o;
  endproperty

  tx_idle_in_reset_a: assert property (tx_idle_in_reset_p)
    else $error("tx line is not idle high while reset is held");

  property exec_quiet_in_reset_p;
    @(posedge clk) (!rst_n_i && reset_seen_q) |-> !exec_o.strobe;
  endproperty

  exec_quiet_in_reset_a: assert property (exec_quiet_in_reset_p)
    else $error("exec strobe is active while reset is held");

  //////////////////////////////////////////////////////////////////////
  // Exec request
  //////////////////////////////////////////////////////////////////////

  property exec_single_cycle_p;
    @(posedge clk) disable iff (!rst_n_i) exec_o.strobe |=> !exec_o.strobe;
  endproperty

  exec_single_cycle_a: assert property (exec_single_cycle_p)
    else $error("exec strobe held for more than one cycle");

endmodule
